/* logic/runner_pkg.sv */
package runner_pkg;

	// Serial link
	localparam int CLK_HZ = 50_000_000;
	localparam int BAUD   = 115_200;
	localparam int OS_DIV = CLK_HZ / (BAUD * 16);  // Clocks per 16x oversample tick, 27

	localparam int TICK_BITS = 10;  // One physics tick per 2**TICK_BITS clocks

	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;

	typedef logic [$clog2(SCREEN_W)-1:0] xpos_t;
	typedef logic [$clog2(SCREEN_H)-1:0] ypos_t;

	// Runner placement and physics
	localparam xpos_t RUNNER_X   = 9'd52;
	localparam ypos_t GROUND_Y   = 8'd109;
	localparam int    JUMP_VEL   = -10;  // Rows per tick at take-off, negative is up
	localparam int    GRAVITY    = 1;
	localparam int    DUCK_TICKS = 40;

	// Runner hitbox inside its 32x32 cell
	localparam int RUNNER_HB_XOFS   = 6;
	localparam int RUNNER_HB_YOFS   = 2;
	localparam int RUNNER_HB_W      = 20;
	localparam int RUNNER_HB_H      = 30;
	localparam int RUNNER_HB_H_DUCK = 15;

	// Obstacle, a square that fills its own hitbox
	localparam int    OBS_SIZE     = 16;
	localparam ypos_t OBS_Y        = 8'd109;
	localparam xpos_t OBS_X_INIT   = xpos_t'(SCREEN_W);
	localparam xpos_t OBS_WRAP_X   = xpos_t'(SCREEN_W - OBS_SIZE);
	localparam int    RESPAWN_SPAN = 100;

	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	typedef logic [15:0] score_t;

	// ASCII command bytes
	typedef enum logic [7:0] {
		CMD_JUMP = 8'h4A,  // "J"
		CMD_DUCK = 8'h44,  // "D"
		CMD_IDLE = 8'h49   // "I"
	} cmd_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

endpackage

/* logic/uart_cmd_rx.sv */
`timescale 1ns/1ps

module uart_cmd_rx (
	input  logic Clock,
	input  logic rst_n,
	input  logic rx,
	output logic cmd_jump,
	output logic cmd_duck,
	output logic cmd_idle
);
	import runner_pkg::*;

	logic [$clog2(OS_DIV)-1:0] div_cnt;
	logic                      os_tick;
	logic                      rx_meta;
	logic                      rx_sync;
	rx_state_e                 state;
	logic [3:0]                os_cnt;   // Oversample ticks left to the next bit middle
	logic [2:0]                bit_idx;
	logic [7:0]                rx_byte;
	logic                      sample_data;

	// Divide the clock down to 16 ticks per bit
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			div_cnt <= '0;
			os_tick <= 1'b0;
		end else if (div_cnt == OS_DIV - 1) begin
			div_cnt <= '0;
			os_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			os_tick <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;  // Line idles high
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	assign sample_data = os_tick && (state == RX_DATA) && (os_cnt == 4'd0);

	// Data bits arrive LSB first, so shift in from the top
	always_ff @(posedge Clock) begin
		if (sample_data)
			rx_byte <= {rx_sync, rx_byte[7:1]};
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state    <= RX_IDLE;
			os_cnt   <= 4'd0;
			bit_idx  <= 3'd0;
			cmd_jump <= 1'b0;
			cmd_duck <= 1'b0;
			cmd_idle <= 1'b0;
		end else begin
			cmd_jump <= 1'b0;
			cmd_duck <= 1'b0;
			cmd_idle <= 1'b0;
			if (os_tick) begin
				case (state)
					RX_IDLE: begin
						if (!rx_sync) begin
							state  <= RX_START;
							os_cnt <= 4'd7;  // Half a bit to the start bit middle
						end
					end
					RX_START: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else if (!rx_sync) begin
							state   <= RX_DATA;
							os_cnt  <= 4'd15;
							bit_idx <= 3'd0;
						end else begin
							state <= RX_IDLE;  // Glitch, not a real start bit
						end
					end
					RX_DATA: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else begin
							os_cnt  <= 4'd15;
							bit_idx <= bit_idx + 1'b1;
							if (bit_idx == 3'd7)
								state <= RX_STOP;
						end
					end
					RX_STOP: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else begin
							state <= RX_IDLE;
							// A low stop bit means a framing error, so the byte is dropped
							if (rx_sync) begin
								case (rx_byte)
									CMD_JUMP: cmd_jump <= 1'b1;
									CMD_DUCK: cmd_duck <= 1'b1;
									CMD_IDLE: cmd_idle <= 1'b1;
									default:  ;
								endcase
							end
						end
					end
				endcase
			end
		end
	end

endmodule

/* logic/runner_jump.sv */
`timescale 1ns/1ps

module runner_jump (
	input  logic              Clock,
	input  logic              rst_n,
	input  logic              phys_tick,
	input  logic              frozen,
	input  logic              jump_req,
	input  logic              duck_req,
	output runner_pkg::ypos_t runner_y,
	output logic              ducking
);
	import runner_pkg::*;

	localparam int YW     = $bits(ypos_t);
	localparam int DUCK_W = $clog2(DUCK_TICKS + 1);

	logic signed [9:0]    vel;       // Rows per tick, negative moves up
	logic                 airborne;
	logic [DUCK_W-1:0]    duck_cnt;
	logic signed [YW+1:0] next_y;
	logic                 jump_start;
	logic                 duck_start;

	assign ducking = (duck_cnt != '0);

	// Two extra bits keep the sum signed and free of wrap
	assign next_y = $signed({2'b00, runner_y}) + vel;

	assign jump_start = jump_req && !airborne && !ducking;
	assign duck_start = duck_req && !airborne && !ducking && !jump_start;

	always_ff @(posedge Clock) begin
		if (!rst_n || frozen) begin
			runner_y <= GROUND_Y;
			vel      <= '0;
			airborne <= 1'b0;
			duck_cnt <= '0;
		end else begin
			if (jump_start) begin
				vel      <= 10'(JUMP_VEL);  // Take-off, first move on the next tick
				airborne <= 1'b1;
			end else if (phys_tick && airborne) begin
				if (next_y >= $signed({2'b00, GROUND_Y})) begin
					runner_y <= GROUND_Y;  // Landed
					vel      <= '0;
					airborne <= 1'b0;
				end else begin
					runner_y <= next_y[YW-1:0];
					vel      <= vel + 10'(GRAVITY);
				end
			end

			if (duck_start)
				duck_cnt <= DUCK_W'(DUCK_TICKS);
			else if (phys_tick && ducking)
				duck_cnt <= duck_cnt - 1'b1;
		end
	end

endmodule

/* logic/obstacle_mover.sv */
`timescale 1ns/1ps

module obstacle_mover (
	input  logic              Clock,
	input  logic              rst_n,
	input  logic              phys_tick,
	input  logic              frozen,
	input  logic              respawn,
	output runner_pkg::xpos_t obstacle_x
);
	import runner_pkg::*;

	logic [15:0] lfsr;
	logic        feedback;
	xpos_t       spawn_ofs;

	assign feedback  = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
	assign spawn_ofs = xpos_t'(lfsr % RESPAWN_SPAN);

	// Free-running, so respawn points differ from game to game
	always_ff @(posedge Clock) begin
		if (!rst_n)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], feedback};
	end

	always_ff @(posedge Clock) begin
		if (!rst_n || frozen) begin
			obstacle_x <= OBS_X_INIT;
		end else if (respawn) begin
			obstacle_x <= OBS_WRAP_X + spawn_ofs;
		end else if (phys_tick) begin
			if (obstacle_x <= xpos_t'(1))
				obstacle_x <= OBS_WRAP_X;  // Left edge reached, back to the right
			else
				obstacle_x <= obstacle_x - 1'b1;
		end
	end

endmodule

/* logic/game_control.sv */
`timescale 1ns/1ps

module game_control (
	input  logic               Clock,
	input  logic               rst_n,
	input  logic               restart,
	input  logic               ducking,
	input  runner_pkg::ypos_t  runner_y,
	input  runner_pkg::xpos_t  obstacle_x,
	output logic               phys_tick,
	output logic               frozen,
	output logic               respawn,
	output logic               game_over,
	output runner_pkg::score_t score,
	output runner_pkg::score_t high_score
);
	import runner_pkg::*;

	logic [TICK_BITS-1:0] tick_cnt;
	logic [9:0]           run_left;
	logic [9:0]           run_right;
	logic [9:0]           obs_left;
	logic [9:0]           obs_right;
	logic [8:0]           run_h;
	logic [8:0]           run_top;
	logic [8:0]           run_bot;
	logic [8:0]           obs_top;
	logic [8:0]           obs_bot;
	logic                 collision;
	logic                 collision_q;
	logic                 game_over_q;
	xpos_t                prev_x;
	logic                 crossing;

	assign frozen = game_over || restart;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			tick_cnt  <= '0;
			phys_tick <= 1'b0;
		end else begin
			tick_cnt  <= tick_cnt + 1'b1;
			phys_tick <= (tick_cnt == '1);
		end
	end

	// Box test with inclusive edges
	assign run_h     = ducking ? 9'(RUNNER_HB_H_DUCK) : 9'(RUNNER_HB_H);
	assign run_left  = 10'(RUNNER_X) + 10'(RUNNER_HB_XOFS);
	assign run_right = run_left + 10'(RUNNER_HB_W);
	assign obs_left  = 10'(obstacle_x);
	assign obs_right = obs_left + 10'(OBS_SIZE);
	assign run_top   = 9'(runner_y) + 9'(RUNNER_HB_YOFS);
	assign run_bot   = run_top + run_h;
	assign obs_top   = 9'(OBS_Y);
	assign obs_bot   = obs_top + 9'(OBS_SIZE);

	assign collision = (run_right >= obs_left) && (run_left <= obs_right) &&
		(run_bot >= obs_top) && (run_top <= obs_bot);

	// Obstacle has just moved past the runner's column
	assign crossing = (prev_x > RUNNER_X) && (obstacle_x <= RUNNER_X);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			game_over   <= 1'b0;
			game_over_q <= 1'b0;
			collision_q <= 1'b0;
			prev_x      <= OBS_X_INIT;
			respawn     <= 1'b0;
			score       <= '0;
			high_score  <= '0;
		end else begin
			game_over_q <= game_over;
			collision_q <= collision;
			prev_x      <= obstacle_x;
			respawn     <= 1'b0;

			if (restart)
				game_over <= 1'b0;
			else if (collision)
				game_over <= 1'b1;

			if (game_over && !game_over_q && (score > high_score))
				high_score <= score;

			if (restart) begin
				score <= '0;
			end else if (!game_over && crossing && !collision && !collision_q) begin
				score   <= score + 1'b1;  // Clean pass
				respawn <= 1'b1;
			end
		end
	end

endmodule

/* logic/score_display.sv */
`timescale 1ns/1ps

module score_display (
	input  runner_pkg::score_t score,
	input  runner_pkg::score_t high_score,
	output logic [6:0]         hex0,
	output logic [6:0]         hex1,
	output logic [6:0]         hex2,
	output logic [6:0]         hex3,
	output logic [6:0]         hex4,
	output logic [6:0]         hex5
);
	logic [3:0] ones;
	logic [3:0] tens;
	logic [3:0] hundreds;
	logic [3:0] hi_ones;
	logic [3:0] hi_tens;
	logic [3:0] hi_hundreds;

	// Active-low segments, bit 0 is segment a
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'd0:    seg7 = 7'b100_0000;
			4'd1:    seg7 = 7'b111_1001;
			4'd2:    seg7 = 7'b010_0100;
			4'd3:    seg7 = 7'b011_0000;
			4'd4:    seg7 = 7'b001_1001;
			4'd5:    seg7 = 7'b001_0010;
			4'd6:    seg7 = 7'b000_0010;
			4'd7:    seg7 = 7'b111_1000;
			4'd8:    seg7 = 7'b000_0000;
			4'd9:    seg7 = 7'b001_0000;
			default: seg7 = 7'b111_1111;  // Blank
		endcase
	endfunction

	assign ones        = 4'(score % 10);
	assign tens        = 4'((score / 10) % 10);
	assign hundreds    = 4'((score / 100) % 10);
	assign hi_ones     = 4'(high_score % 10);
	assign hi_tens     = 4'((high_score / 10) % 10);
	assign hi_hundreds = 4'((high_score / 100) % 10);

	assign hex0 = seg7(ones);
	assign hex1 = seg7(tens);
	assign hex2 = seg7(hundreds);
	assign hex3 = seg7(hi_ones);  // High score on the upper three digits
	assign hex4 = seg7(hi_tens);
	assign hex5 = seg7(hi_hundreds);

endmodule

/* logic/runner_game_top.sv */
`timescale 1ns/1ps

module runner_game_top (
	input  logic              Clock,
	input  logic              rst_n,
	input  logic              rx,
	input  logic              jump_key,
	input  logic              duck_key,
	input  logic              restart,
	output logic              cmd_jump,
	output logic              cmd_duck,
	output logic              cmd_idle,
	output runner_pkg::ypos_t runner_y,
	output runner_pkg::xpos_t obstacle_x,
	output logic              game_over,
	output logic [6:0]        hex0,
	output logic [6:0]        hex1,
	output logic [6:0]        hex2,
	output logic [6:0]        hex3,
	output logic [6:0]        hex4,
	output logic [6:0]        hex5
);
	import runner_pkg::*;

	logic [1:0] jump_sync;
	logic [1:0] duck_sync;
	logic       jump_req;
	logic       duck_req;
	logic       phys_tick;
	logic       frozen;
	logic       respawn;
	logic       ducking;
	score_t     score;
	score_t     high_score;

	// Buttons are asynchronous to Clock
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			jump_sync <= 2'b00;
			duck_sync <= 2'b00;
		end else begin
			jump_sync <= {jump_sync[0], jump_key};
			duck_sync <= {duck_sync[0], duck_key};
		end
	end

	assign jump_req = jump_sync[1] | cmd_jump;
	assign duck_req = duck_sync[1] | cmd_duck;

	uart_cmd_rx u_rx (
		.Clock    (Clock),
		.rst_n    (rst_n),
		.rx       (rx),
		.cmd_jump (cmd_jump),
		.cmd_duck (cmd_duck),
		.cmd_idle (cmd_idle)
	);

	runner_jump u_jump (
		.Clock     (Clock),
		.rst_n     (rst_n),
		.phys_tick (phys_tick),
		.frozen    (frozen),
		.jump_req  (jump_req),
		.duck_req  (duck_req),
		.runner_y  (runner_y),
		.ducking   (ducking)
	);

	obstacle_mover u_obstacle (
		.Clock      (Clock),
		.rst_n      (rst_n),
		.phys_tick  (phys_tick),
		.frozen     (frozen),
		.respawn    (respawn),
		.obstacle_x (obstacle_x)
	);

	game_control u_control (
		.Clock      (Clock),
		.rst_n      (rst_n),
		.restart    (restart),
		.ducking    (ducking),
		.runner_y   (runner_y),
		.obstacle_x (obstacle_x),
		.phys_tick  (phys_tick),
		.frozen     (frozen),
		.respawn    (respawn),
		.game_over  (game_over),
		.score      (score),
		.high_score (high_score)
	);

	score_display u_display (
		.score      (score),
		.high_score (high_score),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5)
	);

endmodule

/* dv/runner_game_tb.sv */
`timescale 1ns/1ps

module runner_game_tb;
	import runner_pkg::*;

	localparam int BIT_CLKS  = OS_DIV * 16;  // Clocks per serial bit
	localparam int TICK_CLKS = 2 ** TICK_BITS;
	localparam int JUMP_COL  = RUNNER_X + RUNNER_HB_XOFS + RUNNER_HB_W + 4;

	logic       Clock;
	logic       rst_n;
	logic       rx;
	logic       jump_key;
	logic       duck_key;
	logic       restart;
	logic       cmd_jump;
	logic       cmd_duck;
	logic       cmd_idle;
	ypos_t      runner_y;
	xpos_t      obstacle_x;
	logic       game_over;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	integer     seed;
	int         errors;
	int         jump_seen;
	int         duck_seen;
	int         idle_seen;
	logic       track;  // Run model follows the game
	logic       track_started;
	xpos_t      last_x;
	logic       last_coll;
	logic       now_coll;
	logic       exp_over;
	score_t     exp_score;
	score_t     exp_high;
	int         respawn_wait;

	runner_game_top u_dut (
		.Clock      (Clock),
		.rst_n      (rst_n),
		.rx         (rx),
		.jump_key   (jump_key),
		.duck_key   (duck_key),
		.restart    (restart),
		.cmd_jump   (cmd_jump),
		.cmd_duck   (cmd_duck),
		.cmd_idle   (cmd_idle),
		.runner_y   (runner_y),
		.obstacle_x (obstacle_x),
		.game_over  (game_over),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5)
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	// Strobe bits are {jump, duck, idle}
	function automatic logic [2:0] ref_decode(input logic [7:0] b);
		if (b == "J")
			return 3'b100;
		else if (b == "D")
			return 3'b010;
		else if (b == "I")
			return 3'b001;
		return 3'b000;
	endfunction

	function automatic int ref_next_y(input int y, input int vel);
		if (y + vel >= int'(GROUND_Y))
			return int'(GROUND_Y);  // Landing snaps to the ground
		return y + vel;
	endfunction

	function automatic logic ref_overlap(input ypos_t y, input xpos_t x, input logic duck);
		int rl;
		int rt;
		int rh;
		rl = int'(RUNNER_X) + RUNNER_HB_XOFS;
		rt = int'(y) + RUNNER_HB_YOFS;
		rh = duck ? RUNNER_HB_H_DUCK : RUNNER_HB_H;
		return (int'(x) <= rl + RUNNER_HB_W) && (rl <= int'(x) + OBS_SIZE) &&
			(int'(OBS_Y) <= rt + rh) && (rt <= int'(OBS_Y) + OBS_SIZE);
	endfunction

	function automatic logic [6:0] ref_seg(input int d);
		logic [6:0] lit;  // Lit segments, bit 0 is a
		case (d)
			0:       lit = 7'h3F;
			1:       lit = 7'h06;
			2:       lit = 7'h5B;
			3:       lit = 7'h4F;
			4:       lit = 7'h66;
			5:       lit = 7'h6D;
			6:       lit = 7'h7D;
			7:       lit = 7'h07;
			8:       lit = 7'h7F;
			default: lit = 7'h6F;
		endcase
		return ~lit;
	endfunction

	function automatic int seg_digit(input logic [6:0] seg);
		int d;
		for (d = 0; d < 10; d++)
			if (ref_seg(d) == seg)
				return d;
		return -1;
	endfunction

	task automatic stop_with_error(input string msg);
		errors++;
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_cmd(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (exp !== act)
			stop_with_error($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_pos(input string name, input ypos_t exp, input ypos_t act);
		if (exp !== act)
			stop_with_error($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_col(input string name, input xpos_t exp, input xpos_t act);
		if (exp !== act)
			stop_with_error($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
			stop_with_error($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_score(input string name, input score_t exp, input logic [6:0] seg_h,
			input logic [6:0] seg_t, input logic [6:0] seg_o);
		int h;
		int t;
		int o;
		score_t act;
		h = seg_digit(seg_h);
		t = seg_digit(seg_t);
		o = seg_digit(seg_o);
		if (h < 0 || t < 0 || o < 0) begin
			stop_with_error($sformatf("%s: the display shows a pattern that is no digit", name));
		end else begin
			act = score_t'(h * 100 + t * 10 + o);
			if (act !== score_t'(exp % 1000))
				stop_with_error($sformatf("Mismatch %s: expected %0d, actual %0d",
					name, exp % 1000, act));
		end
	endtask

	task automatic next_edge();
		@(posedge Clock);
		#1;
	endtask

	always @(negedge Clock) begin
		jump_seen += int'(cmd_jump);
		duck_seen += int'(cmd_duck);
		idle_seen += int'(cmd_idle);
	end

	// Run model, follows score, game over and respawn from the observed positions
	always @(negedge Clock) begin
		if (!track) begin
			track_started = 1'b0;
		end else if (!track_started) begin
			check_flag("game over at game start", 1'b0, game_over);
			check_score("score at game start", 16'd0, hex2, hex1, hex0);
			exp_score     = '0;
			respawn_wait  = 0;
			last_x        = obstacle_x;
			last_coll     = ref_overlap(runner_y, obstacle_x, 1'b0);
			exp_over      = last_coll;
			track_started = 1'b1;
		end else begin
			check_score("running score", exp_score, hex2, hex1, hex0);
			check_flag("game over", exp_over, game_over);
			if (respawn_wait > 0) begin
				respawn_wait--;
				if (respawn_wait == 0)
					check_flag("respawn column in range", 1'b1, (obstacle_x >= OBS_WRAP_X) &&
						(obstacle_x < OBS_WRAP_X + RESPAWN_SPAN));
			end
			now_coll = ref_overlap(runner_y, obstacle_x, 1'b0);
			if (!exp_over && last_x > RUNNER_X && obstacle_x <= RUNNER_X && !now_coll && !last_coll) begin
				exp_score++;
				respawn_wait = 2;  // New column shows two clocks after the crossing
			end
			if (!exp_over && now_coll) begin
				exp_over = 1'b1;
				if (exp_score > exp_high)
					exp_high = exp_score;
			end
			last_x    = obstacle_x;
			last_coll = now_coll;
		end
	end

	task automatic send_byte(input logic [7:0] b);
		int i;
		rx = 1'b0;  // Start bit
		repeat (BIT_CLKS) next_edge();
		for (i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (BIT_CLKS) next_edge();
		end
		rx = 1'b1;
		repeat (BIT_CLKS) next_edge();
	endtask

	task automatic send_and_check(input logic [7:0] b, input string name);
		logic [2:0] exp;
		int waited;
		exp       = ref_decode(b);
		jump_seen = 0;
		duck_seen = 0;
		idle_seen = 0;
		send_byte(b);
		waited = 0;
		// Strobe is due within one bit time after the stop bit
		while (waited < BIT_CLKS && (exp == 3'b000 || jump_seen + duck_seen + idle_seen == 0)) begin
			next_edge();
			waited++;
		end
		if (jump_seen + duck_seen + idle_seen > 1)
			stop_with_error($sformatf("%s: more than one strobe cycle for one byte", name));
		else
			check_cmd(name, exp, {jump_seen != 0, duck_seen != 0, idle_seen != 0});
	endtask

	task automatic pulse_restart();
		restart = 1'b1;
		repeat (4) next_edge();
		restart = 1'b0;
		next_edge();
	endtask

	task automatic press_button(input logic is_jump);
		if (is_jump)
			jump_key = 1'b1;
		else
			duck_key = 1'b1;
		repeat (3) next_edge();
		jump_key = 1'b0;
		duck_key = 1'b0;
	endtask

	task automatic test_commands();
		logic [7:0] b;
		int i;
		restart = 1'b1;  // Game held still
		for (i = 0; i < 23; i++) begin
			if (i == 0)
				b = "J";
			else if (i == 1)
				b = "D";
			else if (i == 2)
				b = "I";
			else
				b = 8'($random(seed));
			send_and_check(b, $sformatf("command byte %0d (8'h%h)", i, b));
			check_score("high score while receiving", 16'd0, hex5, hex4, hex3);
		end
		restart = 1'b0;
	endtask

	task automatic test_jump();
		ypos_t expect_q[$];
		int    y;
		int    vel;
		int    prev;
		int    waited;
		logic  landed;
		ypos_t last;
		pulse_restart();
		y      = GROUND_Y;
		vel    = JUMP_VEL;
		landed = 1'b0;
		while (!landed) begin
			prev   = y;
			y      = ref_next_y(y, vel);
			vel    = vel + GRAVITY;
			landed = (y == int'(GROUND_Y));
			if (y != prev)
				expect_q.push_back(ypos_t'(y));  // Only heights that change are seen
		end
		press_button(1'b1);
		last = runner_y;
		while (expect_q.size() > 0) begin
			waited = 0;
			while (runner_y == last && waited < 3 * TICK_CLKS) begin
				next_edge();
				waited++;
			end
			if (runner_y == last) begin
				stop_with_error("Timeout waiting for the runner to move during a jump");
			end else begin
				check_pos("jump height", expect_q.pop_front(), runner_y);
				last = runner_y;
			end
		end
	endtask

	task automatic test_duck();
		int i;
		pulse_restart();
		press_button(1'b0);
		repeat (8) next_edge();
		press_button(1'b1);  // Inside the duck window
		for (i = 0; i < 4 * TICK_CLKS; i++) begin
			check_pos("height with jump during duck", GROUND_Y, runner_y);
			next_edge();
		end
	endtask

	task automatic test_run();
		int waited;
		track = 1'b0;
		pulse_restart();
		track  = 1'b1;
		waited = 0;
		while (obstacle_x > JUMP_COL && waited < 300 * TICK_CLKS) begin
			next_edge();
			waited++;
		end
		if (obstacle_x > JUMP_COL) begin
			stop_with_error("Timeout waiting for the obstacle to approach the runner");
		end else begin
			press_button(1'b1);  // Airborne before the hitboxes meet
			waited = 0;
			while (!game_over && exp_score == 0 && waited < 100 * TICK_CLKS) begin
				next_edge();
				waited++;
			end
			if (!game_over && exp_score == 0)
				stop_with_error("Timeout waiting for the obstacle to pass the runner");
		end
	endtask

	task automatic test_collision();
		int waited;
		int i;
		track = 1'b0;
		pulse_restart();
		track  = 1'b1;
		waited = 0;
		while (!game_over && waited < 300 * TICK_CLKS) begin
			next_edge();
			waited++;
		end
		if (!game_over) begin
			stop_with_error("Timeout waiting for the obstacle to hit the runner");
		end else begin
			repeat (4) next_edge();
			for (i = 0; i <= TICK_CLKS; i++) begin
				check_pos("runner after game over", GROUND_Y, runner_y);
				check_col("obstacle after game over", OBS_X_INIT, obstacle_x);
				next_edge();
			end
			check_flag("game over held", 1'b1, game_over);
			check_score("high score after game over", exp_high, hex5, hex4, hex3);
		end
	endtask

	task automatic test_restart();
		track = 1'b0;
		pulse_restart();
		check_flag("game over after restart", 1'b0, game_over);
		check_score("score after restart", 16'd0, hex2, hex1, hex0);
		check_score("high score after restart", exp_high, hex5, hex4, hex3);
	endtask

	initial begin
		seed      = 32'hfa03a3e5;
		errors    = 0;
		rst_n     = 1'b0;
		rx        = 1'b1;
		jump_key  = 1'b0;
		duck_key  = 1'b0;
		restart   = 1'b0;
		track     = 1'b0;
		jump_seen = 0;
		duck_seen = 0;
		idle_seen = 0;
		exp_high  = '0;
		repeat (16) @(posedge Clock);
		#1;
		rst_n = 1'b1;
		next_edge();
		check_flag("game over after reset", 1'b0, game_over);
		check_pos("runner after reset", GROUND_Y, runner_y);
		check_col("obstacle after reset", OBS_X_INIT, obstacle_x);
		check_score("score after reset", 16'd0, hex2, hex1, hex0);
		check_score("high score after reset", 16'd0, hex5, hex4, hex3);

		test_commands();
		test_jump();
		test_duck();
		test_run();
		test_collision();
		test_restart();

		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* build.f */
logic/runner_pkg.sv
logic/uart_cmd_rx.sv
logic/runner_jump.sv
logic/obstacle_mover.sv
logic/game_control.sv
logic/score_display.sv
logic/runner_game_top.sv
dv/runner_game_tb.sv

/* Makefile */
sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module runner_game_tb
	@out=$$(./obj_dir/Vrunner_game_tb); echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean
